// File: hw/core_pkg.sv
`default_nettype none

package core_pkg;

    // Widths
    localparam int XLEN       = 64;
    localparam int INST_W     = 32;
    localparam int REG_NUM    = 32;
    localparam int IMEM_WORDS = 256;

    typedef logic [XLEN-1:0]               xlen_t;
    typedef logic [INST_W-1:0]             inst_t;
    typedef logic [$clog2(REG_NUM)-1:0]    reg_addr_t;
    typedef logic [$clog2(IMEM_WORDS)-1:0] imem_addr_t;
    typedef logic [3:0]                    alu_op_t;

    // RISC-V major opcodes handled by decode
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // ALU operation codes
    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_AND  = 4'd2;
    localparam alu_op_t ALU_OR   = 4'd3;
    localparam alu_op_t ALU_XOR  = 4'd4;
    localparam alu_op_t ALU_SLL  = 4'd5;
    localparam alu_op_t ALU_SRL  = 4'd6;
    localparam alu_op_t ALU_SRA  = 4'd7;
    localparam alu_op_t ALU_SLT  = 4'd8;
    localparam alu_op_t ALU_SLTU = 4'd9;
    localparam alu_op_t ALU_LUI  = 4'd10;  // Passes operand B

    localparam inst_t NOP_WORD = 32'h0000_0013;  // addi x0, x0, 0

endpackage

`default_nettype wire

// File: hw/fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_unit import core_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       run,
    input  logic       load_en,
    input  imem_addr_t load_addr,
    input  inst_t      load_data,
    output inst_t      fetch_inst,
    output logic       fetch_valid
);

    xlen_t      pc;
    imem_addr_t fetch_idx;
    inst_t      imem [IMEM_WORDS];

    // Word index wraps around the memory
    assign fetch_idx = pc[9:2];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else if (run) begin
            pc <= pc + xlen_t'(4);
        end
    end

    // Program load port is only used while halted
    always_ff @(posedge clk) begin
        if (load_en) begin
            imem[load_addr] <= load_data;
        end
    end

    assign fetch_inst  = imem[fetch_idx];  // Async read
    assign fetch_valid = run;

endmodule

`default_nettype wire

// File: hw/register_file.sv
`timescale 1ns/10ps
`default_nettype none

module register_file import core_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    output xlen_t     rd1,
    output xlen_t     rd2,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  xlen_t     wr_data
);

    xlen_t regs [REG_NUM];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // x0 is hardwired to zero
    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: hw/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage import core_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  inst_t     fetch_inst,
    input  logic      fetch_valid,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    input  xlen_t     rd1,
    input  xlen_t     rd2,
    input  logic      ex_wr_en,
    input  reg_addr_t ex_rd,
    input  xlen_t     ex_result,
    input  logic      wb_wr_en,
    input  reg_addr_t wb_rd,
    input  xlen_t     wb_data,
    output logic      dec_valid,
    output reg_addr_t dec_rd,
    output logic      dec_wr_en,
    output alu_op_t   dec_alu_op,
    output xlen_t     dec_op_a,
    output xlen_t     dec_op_b
);

    inst_t      d_inst;
    logic       d_valid;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       legal;
    logic       use_imm;
    xlen_t      imm_i;
    xlen_t      imm_u;
    xlen_t      src_b;

    // Newest producer wins and x0 always reads zero
    function automatic xlen_t bypass(
        input reg_addr_t rs,
        input xlen_t     file_val,
        input logic      e_en,
        input reg_addr_t e_dst,
        input xlen_t     e_val,
        input logic      w_en,
        input reg_addr_t w_dst,
        input xlen_t     w_val
    );
        if (rs == '0)                  return '0;
        else if (e_en && e_dst == rs)  return e_val;
        else if (w_en && w_dst == rs)  return w_val;
        else                           return file_val;
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            d_valid <= 1'b0;
        end else begin
            d_valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        d_inst <= fetch_inst;
    end

    assign opcode = d_inst[6:0];
    assign funct3 = d_inst[14:12];
    assign funct7 = d_inst[31:25];
    assign rs1    = d_inst[19:15];
    assign rs2    = d_inst[24:20];

    assign imm_i = {{(XLEN-12){d_inst[31]}}, d_inst[31:20]};
    assign imm_u = {{(XLEN-32){d_inst[31]}}, d_inst[31:12], 12'b0};

    always_comb begin
        legal      = 1'b0;
        use_imm    = 1'b0;
        dec_alu_op = ALU_ADD;
        case (funct3)
            3'b000: dec_alu_op = (opcode == OPC_OP && d_inst[30]) ? ALU_SUB : ALU_ADD;
            3'b001: dec_alu_op = ALU_SLL;
            3'b010: dec_alu_op = ALU_SLT;
            3'b011: dec_alu_op = ALU_SLTU;
            3'b100: dec_alu_op = ALU_XOR;
            3'b101: dec_alu_op = d_inst[30] ? ALU_SRA : ALU_SRL;
            3'b110: dec_alu_op = ALU_OR;
            default: dec_alu_op = ALU_AND;
        endcase
        case (opcode)
            OPC_OP: begin
                legal = (funct7 == 7'b0000000) ||
                        (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            OPC_OP_IMM: begin
                use_imm = 1'b1;
                if (funct3 == 3'b001) begin
                    legal = (d_inst[31:26] == 6'b000000);
                end else if (funct3 == 3'b101) begin
                    legal = (d_inst[31:26] == 6'b000000) || (d_inst[31:26] == 6'b010000);
                end else begin
                    legal = 1'b1;
                end
            end
            OPC_LUI: begin
                legal      = 1'b1;
                use_imm    = 1'b1;
                dec_alu_op = ALU_LUI;
            end
            default: legal = 1'b0;  // Unsupported, no write
        endcase
    end

    assign src_b = bypass(rs2, rd2, ex_wr_en, ex_rd, ex_result, wb_wr_en, wb_rd, wb_data);

    assign dec_valid = d_valid;
    assign dec_rd    = d_inst[11:7];
    assign dec_wr_en = d_valid & legal;
    assign dec_op_a  = bypass(rs1, rd1, ex_wr_en, ex_rd, ex_result, wb_wr_en, wb_rd, wb_data);
    assign dec_op_b  = !use_imm ? src_b : (opcode == OPC_LUI) ? imm_u : imm_i;

endmodule

`default_nettype wire

// File: hw/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage import core_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      dec_valid,
    input  reg_addr_t dec_rd,
    input  logic      dec_wr_en,
    input  alu_op_t   dec_alu_op,
    input  xlen_t     dec_op_a,
    input  xlen_t     dec_op_b,
    output logic      ex_valid,
    output reg_addr_t ex_rd,
    output logic      ex_wr_en,
    output xlen_t     ex_result
);

    logic       e_valid;
    logic       e_wr_en;
    reg_addr_t  e_rd;
    alu_op_t    e_alu_op;
    xlen_t      e_op_a;
    xlen_t      e_op_b;
    logic [5:0] shamt;
    xlen_t      alu_out;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            e_valid <= 1'b0;
            e_wr_en <= 1'b0;
        end else begin
            e_valid <= dec_valid;
            e_wr_en <= dec_wr_en;
        end
    end

    always_ff @(posedge clk) begin
        e_rd     <= dec_rd;
        e_alu_op <= dec_alu_op;
        e_op_a   <= dec_op_a;
        e_op_b   <= dec_op_b;
    end

    assign shamt = e_op_b[5:0];  // RV64 shift amount

    always_comb begin
        case (e_alu_op)
            ALU_ADD:  alu_out = e_op_a + e_op_b;
            ALU_SUB:  alu_out = e_op_a - e_op_b;
            ALU_AND:  alu_out = e_op_a & e_op_b;
            ALU_OR:   alu_out = e_op_a | e_op_b;
            ALU_XOR:  alu_out = e_op_a ^ e_op_b;
            ALU_SLL:  alu_out = e_op_a << shamt;
            ALU_SRL:  alu_out = e_op_a >> shamt;
            ALU_SRA:  alu_out = xlen_t'($signed(e_op_a) >>> shamt);
            ALU_SLT:  alu_out = ($signed(e_op_a) < $signed(e_op_b)) ? xlen_t'(1) : '0;
            ALU_SLTU: alu_out = (e_op_a < e_op_b) ? xlen_t'(1) : '0;
            ALU_LUI:  alu_out = e_op_b;
            default:  alu_out = '0;
        endcase
    end

    assign ex_valid  = e_valid;
    assign ex_rd     = e_rd;
    assign ex_wr_en  = e_wr_en;
    assign ex_result = alu_out;

endmodule

`default_nettype wire

// File: hw/result_stage.sv
`timescale 1ns/10ps
`default_nettype none

module result_stage import core_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      ex_valid,
    input  reg_addr_t ex_rd,
    input  logic      ex_wr_en,
    input  xlen_t     ex_result,
    output logic      wb_wr_en,
    output reg_addr_t wb_rd,
    output xlen_t     wb_data
);

    // Single place where x0 writes are filtered out
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_wr_en <= 1'b0;
        end else begin
            wb_wr_en <= ex_valid & ex_wr_en & (ex_rd != '0);
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= ex_rd;
        wb_data <= ex_result;
    end

endmodule

`default_nettype wire

// File: hw/core_top.sv
`timescale 1ns/10ps
`default_nettype none

module core_top import core_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       run,
    input  logic       load_en,
    input  imem_addr_t load_addr,
    input  inst_t      load_data,
    output logic       retire_valid,
    output reg_addr_t  retire_rd,
    output xlen_t      retire_data
);

    inst_t     fetch_inst;
    logic      fetch_valid;
    reg_addr_t rs1;
    reg_addr_t rs2;
    xlen_t     rd1;
    xlen_t     rd2;
    logic      dec_valid;
    reg_addr_t dec_rd;
    logic      dec_wr_en;
    alu_op_t   dec_alu_op;
    xlen_t     dec_op_a;
    xlen_t     dec_op_b;
    logic      ex_valid;
    reg_addr_t ex_rd;
    logic      ex_wr_en;
    xlen_t     ex_result;
    logic      wb_wr_en;
    reg_addr_t wb_rd;
    xlen_t     wb_data;

    fetch_unit u_fetch_unit (
        .clk         (clk),
        .reset       (reset),
        .run         (run),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .fetch_inst  (fetch_inst),
        .fetch_valid (fetch_valid)
    );

    decode_stage u_decode_stage (
        .clk         (clk),
        .reset       (reset),
        .fetch_inst  (fetch_inst),
        .fetch_valid (fetch_valid),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd1         (rd1),
        .rd2         (rd2),
        .ex_wr_en    (ex_wr_en),
        .ex_rd       (ex_rd),
        .ex_result   (ex_result),
        .wb_wr_en    (wb_wr_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .dec_valid   (dec_valid),
        .dec_rd      (dec_rd),
        .dec_wr_en   (dec_wr_en),
        .dec_alu_op  (dec_alu_op),
        .dec_op_a    (dec_op_a),
        .dec_op_b    (dec_op_b)
    );

    register_file u_register_file (
        .clk     (clk),
        .reset   (reset),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd1     (rd1),
        .rd2     (rd2),
        .wr_en   (wb_wr_en),
        .wr_addr (wb_rd),
        .wr_data (wb_data)
    );

    execute_stage u_execute_stage (
        .clk        (clk),
        .reset      (reset),
        .dec_valid  (dec_valid),
        .dec_rd     (dec_rd),
        .dec_wr_en  (dec_wr_en),
        .dec_alu_op (dec_alu_op),
        .dec_op_a   (dec_op_a),
        .dec_op_b   (dec_op_b),
        .ex_valid   (ex_valid),
        .ex_rd      (ex_rd),
        .ex_wr_en   (ex_wr_en),
        .ex_result  (ex_result)
    );

    result_stage u_result_stage (
        .clk       (clk),
        .reset     (reset),
        .ex_valid  (ex_valid),
        .ex_rd     (ex_rd),
        .ex_wr_en  (ex_wr_en),
        .ex_result (ex_result),
        .wb_wr_en  (wb_wr_en),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

    // Retire port mirrors the write-back
    assign retire_valid = wb_wr_en;
    assign retire_rd    = wb_rd;
    assign retire_data  = wb_data;

endmodule

`default_nettype wire

// File: test/core_props.sv
`timescale 1ns/10ps
`default_nettype none

module core_props import core_pkg::*; (
    input logic      clk,
    input logic      reset,
    input logic      run,
    input logic      retire_valid,
    input reg_addr_t retire_rd
);

    a_quiet_in_reset: assert property (@(posedge clk) reset |-> !retire_valid)
        else $error("retire_valid high during reset");

    // Write-back to x0 must never show on the retire port
    a_rd_nonzero: assert property (@(posedge clk) disable iff (reset)
        retire_valid |-> retire_rd != '0)
        else $error("retire with rd of zero");

    // Pipeline is three deep, so it drains three cycles after run drops
    a_drained: assert property (@(posedge clk) disable iff (reset)
        (!run [*3]) |=> !retire_valid)
        else $error("retire after run was low for three cycles");

endmodule

bind core_top core_props u_core_props (
    .clk          (clk),
    .reset        (reset),
    .run          (run),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd)
);

`default_nettype wire

// File: test/tb_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_core import core_pkg::*; ();

    logic       clk;
    logic       reset;
    logic       run;
    logic       load_en;
    imem_addr_t load_addr;
    inst_t      load_data;
    logic       retire_valid;
    reg_addr_t  retire_rd;
    xlen_t      retire_data;

    // Word 0 program length, word 1 retire count, then program, then rd/value pairs
    xlen_t test_mem [2*IMEM_WORDS];
    int    prog_len;
    int    exp_len;
    int    retire_count = 0;

    core_top u_core_top (
        .clk          (clk),
        .reset        (reset),
        .run          (run),
        .load_en      (load_en),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    // addi x0, x0, addr so every filler word differs
    function automatic inst_t filler_word(input int addr);
        return NOP_WORD | (inst_t'(addr) << 20);
    endfunction

    task automatic check_retire();
        int        base;
        reg_addr_t exp_rd;
        xlen_t     exp_data;
        assert (retire_count < exp_len) else begin
            $display("Unexpected retire of x%0d at %0t after the last expected entry",
                     retire_rd, $time);
            abort_run();
        end
        base     = 2 + prog_len + 2 * retire_count;
        exp_rd   = reg_addr_t'(test_mem[base]);
        exp_data = test_mem[base + 1];
        assert (retire_rd == exp_rd) else begin
            $display("FAILED at %0t: retire_rd expected %0d, actual %0d",
                     $time, exp_rd, retire_rd);
            abort_run();
        end
        assert (retire_data == exp_data) else begin
            $display("FAILED at %0t: retire_data (x%0d) expected %h, actual %h",
                     $time, exp_rd, exp_data, retire_data);
            abort_run();
        end
        retire_count++;
    endtask

    // Retire port is registered and stable at the edge
    always @(posedge clk) begin
        if (!reset && retire_valid) begin
            check_retire();
        end
    end

    initial begin
        reset     = 1'b1;
        run       = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        $readmemh("test/core_tests.txt", test_mem);
        prog_len = int'(test_mem[0]);
        exp_len  = int'(test_mem[1]);
        assert (prog_len <= IMEM_WORDS) else begin
            $display("Program in the data file is longer than the instruction memory");
            abort_run();
        end

        repeat (8) @(posedge clk);
        #1 reset = 1'b0;

        for (int idx = 0; idx < IMEM_WORDS; idx++) begin
            @(posedge clk);
            #1;
            load_en   = 1'b1;
            load_addr = imem_addr_t'(idx);
            load_data = (idx < prog_len) ? inst_t'(test_mem[2 + idx]) : filler_word(idx);
        end
        @(posedge clk);
        #1;
        load_en = 1'b0;
        run     = 1'b1;

        wait (retire_count == exp_len);
        @(posedge clk);
        #1 run = 1'b0;  // Stop before the PC wraps into the program again

        // Quiet drain period
        repeat (256) @(posedge clk);
        $display("*** TEST PASSED ***");
        $finish;
    end

    initial begin
        int limit_ns;
        #1;
        limit_ns = (IMEM_WORDS + prog_len + 300) * 4;
        #(limit_ns);
        $display("Timeout after %0d ns, only %0d of %0d expected retires seen",
                 limit_ns, retire_count, exp_len);
        abort_run();
    end

endmodule

`default_nettype wire

// File: compile.f
hw/core_pkg.sv
hw/fetch_unit.sv
hw/register_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/result_stage.sv
hw/core_top.sv
test/core_props.sv
test/tb_core.sv

// File: Makefile
TOP := tb_core

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f -o $(TOP)

# The model may exit early on failure, so the log decides the result
run: build
	./obj_dir/$(TOP) | tee run.log
	grep -qF "*** TEST PASSED ***" run.log

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir run.log

// File: test/core_tests.txt
// Program length and expected retire count, then program words (hex)
// Then expected retires, one per line as rd and 64-bit value
1F 1C
00500093 FFD00113 06400193 00208233 // addi x1,x2,x3 then add x4 (bypass wb, regfile)
00A20293 40428333 00708013 006003B3 // addi x5, sub x6, addi x0, add x7 from x0
FFF00413 800004B7 12345537 4044D593 // addi x8, lui x9 x10, srai x11
0044D613 00851693 00112733 001137B3 // srli x12, slli x13, slt x14, sltu x15
FFE12813 FFF0B893 00A44933 003979B3 // slti x16, sltiu x17, xor x18, and x19
00A9EA33 04100B13 01609AB3 41615BB3 // or x20, addi x22 65, sll x21, sra x23
01645C33 001C0C93 401C8D33 00003D83 // srl x24, addi x25, sub x26, ld (no write)
02108E33 01CD8EB3 01DD0F33          // mul (no write), add x29, add x30
01 0000000000000005
02 FFFFFFFFFFFFFFFD
03 0000000000000064
04 0000000000000002
05 000000000000000C
06 000000000000000A
07 000000000000000A
08 FFFFFFFFFFFFFFFF
09 FFFFFFFF80000000
0A 0000000012345000
0B FFFFFFFFF8000000
0C 0FFFFFFFF8000000
0D 0000001234500000
0E 0000000000000001
0F 0000000000000000
10 0000000000000001
11 0000000000000001
12 FFFFFFFFEDCBAFFF
13 0000000000000064
14 0000000012345064
16 0000000000000041
15 000000000000000A
17 FFFFFFFFFFFFFFFE
18 7FFFFFFFFFFFFFFF
19 8000000000000000
1A 7FFFFFFFFFFFFFFB
1D 0000000000000000
1E 7FFFFFFFFFFFFFFB
